// ==== tag_fe.f ====
+incdir+.
axi_req_pkg.sv
tag_fe_pkg.sv
req_if.sv
index_extractor.sv
tag_lookup.sv
req_fifo.sv
tag_fe_top.sv
tag_fe_asserts.sv
tb_tag_fe.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_tag_fe
FILELIST  ?= tag_fe.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := tag_fe_consts.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source, the header or the file list changes
$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx 'Test passed' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb_tag_fe.sv ====
`timescale 1ns/1ps
`include "tag_fe_consts.svh"

module tb_tag_fe;
	import axi_req_pkg::*;

	localparam int CLK_PERIOD = 100;
	localparam int ENTRIES    = 1 << `TFE_INDEX_WIDTH;
	localparam int DEPTH      = `TFE_FIFO_DEPTH;

	localparam logic [1:0] K_RD   = 2'd0;
	localparam logic [1:0] K_WR   = 2'd1;
	localparam logic [1:0] K_BOTH = 2'd2; // AR and AW offered together
	localparam logic [1:0] K_RST  = 2'd3;

	typedef struct packed {
		logic [1:0]                 kind;
		logic [`TFE_ID_WIDTH-1:0]   ar_id;
		logic [`TFE_ADDR_WIDTH-1:0] ar_addr;
		logic [`TFE_ID_WIDTH-1:0]   aw_id;
		logic [`TFE_ADDR_WIDTH-1:0] aw_addr;
		logic [7:0]                 stall;  // rsp ready held low this many cycles
		logic                       drain;  // wait for every response before next row
		logic [1:0]                 ar_hit; // 2 means no expectation given
		logic [1:0]                 aw_hit;
	} row_t;

	typedef struct packed {
		req_op_e                    op;
		logic [`TFE_ID_WIDTH-1:0]   id;
		logic [`TFE_ADDR_WIDTH-1:0] addr;
		logic                       hit;
		logic                       lat;
		logic [31:0]                cyc; // cycle the valid went high
	} exp_t;

	logic                       clk;
	logic                       rst_n;
	logic [`TFE_ID_WIDTH-1:0]   arid;
	logic [`TFE_ADDR_WIDTH-1:0] araddr;
	logic                       arvalid;
	logic                       arready;
	logic [`TFE_ID_WIDTH-1:0]   awid;
	logic [`TFE_ADDR_WIDTH-1:0] awaddr;
	logic                       awvalid;
	logic                       awready;
	logic                       rsp_valid;
	req_op_e                    rsp_op;
	logic [`TFE_ID_WIDTH-1:0]   rsp_id;
	logic [`TFE_ADDR_WIDTH-1:0] rsp_addr;
	logic                       rsp_hit;
	logic                       rsp_ready;

	// reference model of the tag table and arbiter
	logic [ENTRIES-1:0]        m_valid;
	logic [`TFE_TAG_WIDTH-1:0] m_tag [ENTRIES];
	logic                      m_prefer_wr;

	row_t rows[$];
	exp_t exp_q[$];
	int   cycle;
	int   stall_left;
	int   seed;
	int   n_rows;
	logic table_done;

	tag_fe_top dut0 (
		.clk         (clk),
		.rst_n       (rst_n),
		.arid_i      (arid),
		.araddr_i    (araddr),
		.arvalid_i   (arvalid),
		.arready_o   (arready),
		.awid_i      (awid),
		.awaddr_i    (awaddr),
		.awvalid_i   (awvalid),
		.awready_o   (awready),
		.rsp_valid_o (rsp_valid),
		.rsp_op_o    (rsp_op),
		.rsp_id_o    (rsp_id),
		.rsp_addr_o  (rsp_addr),
		.rsp_hit_o   (rsp_hit),
		.rsp_ready_i (rsp_ready)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			$display("FAILED at time %0t: %s is %0h, expected %0h", $time, name, got, exp);
			$display("Test failed");
			$fatal(1, "wrong value on %s", name);
		end
	endtask

	task automatic check_rsp();
		exp_t e;
		if (exp_q.size() == 0) begin
			$display("a response came out that no request accounts for, id %0h addr %0h",
				rsp_id, rsp_addr);
			$display("Test failed");
			$fatal(1, "unexpected response");
		end else begin
			e = exp_q.pop_front();
			check_val("rsp_op_o", 64'(rsp_op), 64'(e.op));
			check_val("rsp_id_o", 64'(rsp_id), 64'(e.id));
			check_val("rsp_addr_o", rsp_addr, e.addr);
			check_val("rsp_hit_o", 64'(rsp_hit), 64'(e.hit));
			if (e.lat) begin
				check_val("response latency", 64'(32'(cycle) - e.cyc), 64'd3);
			end
		end
	endtask

	// one cycle, ending on the falling edge with the response side serviced
	task automatic step();
		@(negedge clk);
		cycle++;
		rsp_ready = (stall_left == 0);
		if (stall_left > 0) begin
			stall_left--;
		end
		if (rsp_valid && rsp_ready) begin
			check_rsp();
		end
	endtask

	task automatic accept(input req_op_e op, input logic [`TFE_ID_WIDTH-1:0] id,
			input logic [`TFE_ADDR_WIDTH-1:0] addr, input logic [1:0] tbl_hit,
			input logic lat, input int cyc);
		exp_t                        e;
		logic [`TFE_INDEX_WIDTH-1:0] idx;
		logic [`TFE_TAG_WIDTH-1:0]   tag;
		idx    = addr[`TFE_INDEX_WIDTH-1:0];
		tag    = addr[`TFE_ADDR_WIDTH-1:`TFE_INDEX_WIDTH];
		e.op   = op;
		e.id   = id;
		e.addr = addr;
		e.hit  = m_valid[idx] && (m_tag[idx] == tag);
		e.lat  = lat;
		e.cyc  = 32'(cyc);
		if (tbl_hit != 2'd2) begin
			check_val("expected hit in table", 64'(tbl_hit), 64'(e.hit));
		end
		m_valid[idx] = 1'b1; // reads allocate as well
		m_tag[idx]   = tag;
		m_prefer_wr  = (op == REQ_READ);
		exp_q.push_back(e);
	endtask

	task automatic offer(input row_t r);
		logic ar_fire;
		logic aw_fire;
		logic lat;
		int   start;
		start   = cycle;
		lat     = r.drain && (r.kind != K_BOTH) && (exp_q.size() == 0) && (stall_left == 0);
		arid    = r.ar_id;
		araddr  = r.ar_addr;
		arvalid = (r.kind != K_WR);
		awid    = r.aw_id;
		awaddr  = r.aw_addr;
		awvalid = (r.kind != K_RD);
		while (arvalid || awvalid) begin
			// with this many outstanding the FIFO is almost full
			if (exp_q.size() >= DEPTH - 1) begin
				check_val("arready_o", 64'(arready), 64'd0);
				check_val("awready_o", 64'(awready), 64'd0);
			end
			ar_fire = arvalid && arready;
			aw_fire = awvalid && awready;
			if (arvalid && awvalid && (ar_fire || aw_fire)) begin
				check_val("awready_o on a tie", 64'(aw_fire), 64'(m_prefer_wr));
			end
			step();
			if (ar_fire) begin
				arvalid = 1'b0;
				accept(REQ_READ, r.ar_id, r.ar_addr, r.ar_hit, lat, start);
			end
			if (aw_fire) begin
				awvalid = 1'b0;
				accept(REQ_WRITE, r.aw_id, r.aw_addr, r.aw_hit, lat, start);
			end
		end
		check_val("arready_o", 64'(arready), 64'd0); // one pulse per request
		check_val("awready_o", 64'(awready), 64'd0);
	endtask

	task automatic apply_reset();
		rst_n = 1'b0;
		exp_q.delete();
		stall_left  = 0;
		m_valid     = '0;
		m_prefer_wr = 1'b0;
		repeat (3) step();
		check_val("rsp_valid_o", 64'(rsp_valid), 64'd0);
		rst_n = 1'b1;
	endtask

	task automatic drain();
		while (exp_q.size() != 0) begin
			step();
		end
	endtask

	task automatic add_row(input logic [1:0] kind, input logic [15:0] ar_id,
			input logic [63:0] ar_addr, input logic [15:0] aw_id, input logic [63:0] aw_addr,
			input logic [7:0] stall, input logic drain, input logic [1:0] ar_hit,
			input logic [1:0] aw_hit);
		row_t r;
		r.kind    = kind;
		r.ar_id   = ar_id;
		r.ar_addr = ar_addr;
		r.aw_id   = aw_id;
		r.aw_addr = aw_addr;
		r.stall   = stall;
		r.drain   = drain;
		r.ar_hit  = ar_hit;
		r.aw_hit  = aw_hit;
		rows.push_back(r);
	endtask

	// four tags over four indices so repeats are common
	function automatic logic [63:0] pool_addr();
		logic [31:0] r;
		r = $random(seed);
		return {48'h0, 4'hc, 4'h0, 2'b00, r[5:4], 2'b00, r[1:0]};
	endfunction

	task automatic fill_table();
		logic [1:0]  kind;
		logic [63:0] addr;
		logic [31:0] r;
		logic [7:0]  stall;
		add_row(K_RD, 16'h0001, 64'h1000, 16'h0000, 64'h0, 8'd0, 1'b1, 2'd0, 2'd2);
		add_row(K_WR, 16'h0000, 64'h0, 16'h0002, 64'h2001, 8'd0, 1'b1, 2'd2, 2'd0);
		add_row(K_RD, 16'h0003, 64'h1000, 16'h0000, 64'h0, 8'd0, 1'b1, 2'd1, 2'd2);
		add_row(K_WR, 16'h0000, 64'h0, 16'h0004, 64'h5000, 8'd0, 1'b1, 2'd2, 2'd0);
		add_row(K_RD, 16'h0005, 64'h1000, 16'h0000, 64'h0, 8'd0, 1'b1, 2'd0, 2'd2);
		add_row(K_BOTH, 16'h0006, 64'h3002, 16'h0007, 64'h4003, 8'd0, 1'b0, 2'd0, 2'd0);
		add_row(K_BOTH, 16'h0008, 64'h3002, 16'h0009, 64'h4013, 8'd0, 1'b0, 2'd1, 2'd0);
		add_row(K_WR, 16'h0000, 64'h0, 16'h000a, 64'h2001, 8'd0, 1'b0, 2'd2, 2'd1);
		add_row(K_BOTH, 16'h000b, 64'h4003, 16'h000c, 64'h2001, 8'd0, 1'b1, 2'd0, 2'd1);
		// more requests than the FIFO holds while responses are stalled
		for (int i = 0; i < 10; i++) begin
			kind  = i[0] ? K_WR : K_RD;
			addr  = 64'h0a00 + 64'(i + 4);
			stall = (i == 0) ? 8'd60 : 8'd0;
			add_row(kind, 16'(32'h20 + i), addr, 16'(32'h20 + i), addr, stall, 1'b0,
				(kind == K_RD) ? 2'd0 : 2'd2, (kind == K_WR) ? 2'd0 : 2'd2);
		end
		add_row(K_RD, 16'h002a, 64'h0a04, 16'h0000, 64'h0, 8'd0, 1'b1, 2'd1, 2'd2);
		// reset with responses still queued
		add_row(K_RD, 16'h0030, 64'h0a05, 16'h0000, 64'h0, 8'd20, 1'b0, 2'd1, 2'd2);
		add_row(K_WR, 16'h0000, 64'h0, 16'h0031, 64'h0a06, 8'd0, 1'b0, 2'd2, 2'd1);
		add_row(K_RST, 16'h0000, 64'h0, 16'h0000, 64'h0, 8'd0, 1'b0, 2'd2, 2'd2);
		add_row(K_BOTH, 16'h0040, 64'h1000, 16'h0041, 64'h0a04, 8'd0, 1'b1, 2'd0, 2'd0);
		for (int i = 0; i < 40; i++) begin
			r     = $random(seed);
			kind  = 2'(r % 3);
			stall = (r[10:8] == 3'd0) ? 8'(5 + r[15:12]) : 8'd0;
			addr  = pool_addr();
			add_row(kind, 16'($random(seed)), addr, 16'($random(seed)), pool_addr(), stall,
				1'b0, 2'd2, 2'd2);
		end
	endtask

	initial begin
		table_done  = 1'b0;
		rst_n       = 1'b0;
		arid        = '0;
		araddr      = '0;
		arvalid     = 1'b0;
		awid        = '0;
		awaddr      = '0;
		awvalid     = 1'b0;
		rsp_ready   = 1'b0;
		seed        = 32'h9674fc6b;
		cycle       = 0;
		stall_left  = 0;
		m_valid     = '0;
		m_prefer_wr = 1'b0;
		fill_table();
		n_rows     = rows.size();
		table_done = 1'b1;
		apply_reset();
		foreach (rows[i]) begin
			if (rows[i].stall != 8'd0) begin
				stall_left = int'(rows[i].stall);
			end
			if (rows[i].kind == K_RST) begin
				apply_reset();
			end else begin
				offer(rows[i]);
				if (rows[i].drain) begin
					drain();
				end
			end
		end
		drain();
		repeat (5) step(); // a stray extra response would show up here
		$display("Test passed");
		$finish;
	end

	initial begin
		wait (table_done);
		#(n_rows * 20 * CLK_PERIOD);
		$display("the run timed out waiting on the DUT after %0d rows", n_rows);
		$display("Test failed");
		$fatal(1, "timeout");
	end

endmodule

// ==== tag_fe_asserts.sv ====
`timescale 1ns/1ps
`include "tag_fe_consts.svh"

module tag_fe_asserts (
	input logic                       clk,
	input logic                       rst_n,
	input logic                       arvalid_i,
	input logic                       arready_o,
	input logic                       awvalid_i,
	input logic                       awready_o,
	input logic                       rsp_valid_o,
	input axi_req_pkg::req_op_e       rsp_op_o,
	input logic [`TFE_ID_WIDTH-1:0]   rsp_id_o,
	input logic [`TFE_ADDR_WIDTH-1:0] rsp_addr_o,
	input logic                       rsp_hit_o,
	input logic                       rsp_ready_i
);

	// only one address channel is captured at a time
	a_one_ready: assert property (@(posedge clk) !(arready_o && awready_o))
		else $error("arready_o and awready_o high in the same cycle");

	a_ar_ready: assert property (@(posedge clk) disable iff (!rst_n) arready_o |-> arvalid_i)
		else $error("arready_o high without arvalid_i");

	a_aw_ready: assert property (@(posedge clk) disable iff (!rst_n) awready_o |-> awvalid_i)
		else $error("awready_o high without awvalid_i");

	// a stalled response keeps its word
	a_rsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
		rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_op_o) && $stable(rsp_id_o)
			&& $stable(rsp_addr_o) && $stable(rsp_hit_o))
		else $error("response dropped or changed while stalled");

	a_reset_idle: assert property (@(posedge clk)
		!rst_n |=> !arready_o && !awready_o && !rsp_valid_o)
		else $error("output active during reset");

endmodule

bind tag_fe_top tag_fe_asserts u_asserts (.*);

// ==== tag_fe_top.sv ====
`timescale 1ns/1ps
`include "tag_fe_consts.svh"

module tag_fe_top (
	input  logic                       clk,
	input  logic                       rst_n,

	input  logic [`TFE_ID_WIDTH-1:0]   arid_i,
	input  logic [`TFE_ADDR_WIDTH-1:0] araddr_i,
	input  logic                       arvalid_i,
	output logic                       arready_o,

	input  logic [`TFE_ID_WIDTH-1:0]   awid_i,
	input  logic [`TFE_ADDR_WIDTH-1:0] awaddr_i,
	input  logic                       awvalid_i,
	output logic                       awready_o,

	output logic                       rsp_valid_o,
	output axi_req_pkg::req_op_e       rsp_op_o,
	output logic [`TFE_ID_WIDTH-1:0]   rsp_id_o,
	output logic [`TFE_ADDR_WIDTH-1:0] rsp_addr_o,
	output logic                       rsp_hit_o,
	input  logic                       rsp_ready_i
);
	import tag_fe_pkg::*;

	logic     fifo_afull;
	tag_rsp_t rsp;

	req_if ri ();

	index_extractor u_ext (
		.clk          (clk),
		.rst_n        (rst_n),
		.arid_i       (arid_i),
		.araddr_i     (araddr_i),
		.arvalid_i    (arvalid_i),
		.arready_o    (arready_o),
		.awid_i       (awid_i),
		.awaddr_i     (awaddr_i),
		.awvalid_i    (awvalid_i),
		.awready_o    (awready_o),
		.fifo_afull_i (fifo_afull),
		.req_o        (ri.ext)
	);

	tag_lookup u_lookup (
		.clk   (clk),
		.rst_n (rst_n),
		.lk_i  (ri.lookup)
	);

	req_fifo u_fifo (
		.clk           (clk),
		.rst_n         (rst_n),
		.wr_i          (ri.fifo),
		.almost_full_o (fifo_afull),
		.rsp_valid_o   (rsp_valid_o),
		.rsp_o         (rsp),
		.rsp_ready_i   (rsp_ready_i)
	);

	// flatten the queued word onto the response port
	assign rsp_op_o   = rsp.req.op;
	assign rsp_id_o   = rsp.req.id;
	assign rsp_addr_o = rsp.req.addr;
	assign rsp_hit_o  = rsp.hit;

endmodule

// ==== req_fifo.sv ====
`timescale 1ns/1ps
`include "tag_fe_consts.svh"

module req_fifo #(
	parameter int DEPTH = `TFE_FIFO_DEPTH
) (
	input  logic                  clk,
	input  logic                  rst_n,
	req_if.fifo                   wr_i,
	output logic                  almost_full_o,
	output logic                  rsp_valid_o,
	output tag_fe_pkg::tag_rsp_t  rsp_o,
	input  logic                  rsp_ready_i
);
	import tag_fe_pkg::*;

	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);

	tag_rsp_t         mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr, rd_ptr;
	logic [CNT_W-1:0] count;
	logic             full;
	logic             push;
	logic             pop;

	// wrap by hand so a depth that is not a power of two still works
	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
		logic [PTR_W-1:0] nxt;
		if (p == PTR_W'(DEPTH - 1)) begin
			nxt = '0;
		end else begin
			nxt = p + 1'b1;
		end
		return nxt;
	endfunction

	assign full          = (count == CNT_W'(DEPTH));
	assign push          = wr_i.wr_en && !full;
	assign pop           = rsp_valid_o && rsp_ready_i;
	assign rsp_valid_o   = (count != '0);
	assign rsp_o         = mem[rd_ptr];
	assign almost_full_o = (count >= CNT_W'(DEPTH - 2)); // two slots left covers one in flight

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= ptr_inc(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= ptr_inc(rd_ptr);
			end
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // both or neither
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= '{req: wr_i.req, hit: wr_i.hit};
		end
	end

endmodule

// ==== tag_lookup.sv ====
`timescale 1ns/1ps
`include "tag_fe_consts.svh"

module tag_lookup (
	input  logic clk,
	input  logic rst_n,
	req_if.lookup lk_i
);
	localparam int ENTRIES = 1 << `TFE_INDEX_WIDTH;

	logic [ENTRIES-1:0]        valid_q;
	logic [`TFE_TAG_WIDTH-1:0] tag_q [ENTRIES];
	logic [`TFE_TAG_WIDTH-1:0] req_tag;
	logic                      tag_match;

	assign req_tag   = lk_i.req.addr[`TFE_ADDR_WIDTH-1:`TFE_INDEX_WIDTH];
	assign tag_match = (tag_q[lk_i.index] == req_tag);

	// hit only means something during the wr_en cycle
	assign lk_i.hit = lk_i.wr_en && valid_q[lk_i.index] && tag_match;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid_q <= '0;
		end else if (lk_i.wr_en) begin
			valid_q[lk_i.index] <= 1'b1;
		end
	end

	// reads allocate too, so a repeat of either op hits
	always_ff @(posedge clk) begin
		if (lk_i.wr_en) begin
			tag_q[lk_i.index] <= req_tag; // a different tag evicts the old one
		end
	end

endmodule

// ==== index_extractor.sv ====
`timescale 1ns/1ps
`include "tag_fe_consts.svh"

module index_extractor (
	input  logic                       clk,
	input  logic                       rst_n,

	input  logic [`TFE_ID_WIDTH-1:0]   arid_i,
	input  logic [`TFE_ADDR_WIDTH-1:0] araddr_i,
	input  logic                       arvalid_i,
	output logic                       arready_o,

	input  logic [`TFE_ID_WIDTH-1:0]   awid_i,
	input  logic [`TFE_ADDR_WIDTH-1:0] awaddr_i,
	input  logic                       awvalid_i,
	output logic                       awready_o,

	input  logic                       fifo_afull_i,
	req_if.ext                         req_o
);
	import axi_req_pkg::*;
	import tag_fe_pkg::*;

	ext_state_e                  state, state_n;
	logic                        prefer_wr, prefer_wr_n; // round-robin flag
	logic                        wr_en, wr_en_n;
	logic [`TFE_INDEX_WIDTH-1:0] index, index_n;
	axi_req_t                    req, req_n;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state     <= S_IDLE;
			prefer_wr <= 1'b0; // first tie goes to read
			wr_en     <= 1'b0;
		end else begin
			state     <= state_n;
			prefer_wr <= prefer_wr_n;
			wr_en     <= wr_en_n;
		end
	end

	always_ff @(posedge clk) begin
		index <= index_n;
		req   <= req_n;
	end

	always_comb begin
		state_n     = state;
		prefer_wr_n = prefer_wr;
		wr_en_n     = 1'b0;
		index_n     = index;
		req_n       = req;

		case (state)
			S_IDLE: begin
				// hold off while the fifo may not take another entry
				if (!fifo_afull_i) begin
					if (arvalid_i && (!awvalid_i || !prefer_wr)) begin
						state_n     = S_RREQ;
						prefer_wr_n = 1'b1;
					end else if (awvalid_i) begin
						state_n     = S_WREQ;
						prefer_wr_n = 1'b0;
					end
				end
			end
			S_RREQ: begin
				index_n    = araddr_i[`TFE_INDEX_WIDTH-1:0];
				req_n.op   = REQ_READ;
				req_n.id   = arid_i;
				req_n.addr = araddr_i;
				wr_en_n    = 1'b1;
				state_n    = S_IDLE;
			end
			S_WREQ: begin
				index_n    = awaddr_i[`TFE_INDEX_WIDTH-1:0];
				req_n.op   = REQ_WRITE;
				req_n.id   = awid_i;
				req_n.addr = awaddr_i;
				wr_en_n    = 1'b1;
				state_n    = S_IDLE;
			end
			default: state_n = S_IDLE;
		endcase
	end

	// ready only in the capture cycle, so each handshake is one beat
	assign arready_o = (state == S_RREQ);
	assign awready_o = (state == S_WREQ);

	assign req_o.wr_en = wr_en;
	assign req_o.index = index;
	assign req_o.req   = req;

endmodule

// ==== req_if.sv ====
`timescale 1ns/1ps
`include "tag_fe_consts.svh"

// one captured request, valid only in the cycle wr_en is high
interface req_if;
	import axi_req_pkg::*;

	logic                        wr_en;
	logic [`TFE_INDEX_WIDTH-1:0] index;
	axi_req_t                    req;
	logic                        hit; // combinational from the tag table

	modport ext (
		output wr_en,
		output index,
		output req
	);

	modport lookup (
		input  wr_en,
		input  index,
		input  req,
		output hit
	);

	modport fifo (
		input wr_en,
		input req,
		input hit
	);

endinterface

// ==== tag_fe_pkg.sv ====
`include "tag_fe_consts.svh"

package tag_fe_pkg;

	// extractor FSM
	typedef enum logic [1:0] {
		S_IDLE = 2'd0,
		S_RREQ = 2'd1, // AR capture cycle
		S_WREQ = 2'd2  // AW capture cycle
	} ext_state_e;

	// queued response word, request plus lookup result
	typedef struct packed {
		axi_req_pkg::axi_req_t req;
		logic                  hit;
	} tag_rsp_t;

endpackage

// ==== axi_req_pkg.sv ====
`include "tag_fe_consts.svh"

package axi_req_pkg;

	// which AXI address channel a request came in on
	typedef enum logic {
		REQ_READ  = 1'b0,
		REQ_WRITE = 1'b1
	} req_op_e;

	// one captured address request, 1 + 16 + 64 bits
	// op sits in the top bit
	typedef struct packed {
		req_op_e                    op;
		logic [`TFE_ID_WIDTH-1:0]   id;
		logic [`TFE_ADDR_WIDTH-1:0] addr;
	} axi_req_t;

endpackage

// ==== tag_fe_consts.svh ====
`ifndef TAG_FE_CONSTS_SVH
`define TAG_FE_CONSTS_SVH

// AXI address and ID widths as seen on the slave port
`define TFE_ADDR_WIDTH 64
`define TFE_ID_WIDTH 16

// low address bits select one of 2**TFE_INDEX_WIDTH table entries
`define TFE_INDEX_WIDTH 4

// the tag is whatever sits above the index
`define TFE_TAG_WIDTH (`TFE_ADDR_WIDTH - `TFE_INDEX_WIDTH)

// response queue entries
`define TFE_FIFO_DEPTH 8

`endif
